/* soc.f */
+incdir+.
soc_pkg.sv
mem_bus_if.sv
bus_decoder.sv
ram_bank.sv
clint.sv
response_mux.sv
soc.sv
soc_asserts.sv
soc_tb.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f soc.f
	./obj_dir/Vsoc_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	  test $$status -eq 0 && ! grep -q "FAIL: see errors above" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* soc_tb.sv */
`default_nettype none

`include "soc_config.svh"

module soc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RAM_WORDS      = `NUM_BANKS * `BANK_WORDS;
  localparam int RAM_BYTES      = RAM_WORDS * 4;
  localparam int NUM_RAM_OPS    = 400;
  localparam int NUM_MISS_OPS   = 40;
  localparam int NUM_CLINT_REQS = 32;
  localparam int NUM_REQS       = RAM_WORDS + NUM_RAM_OPS + 2 * NUM_MISS_OPS + NUM_CLINT_REQS;
  localparam int TIMEOUT_CYCLES = 4 * NUM_REQS + 200;

  logic           clock;
  logic           rst_n;
  logic           mem_valid;
  soc_pkg::addr_t mem_addr;
  soc_pkg::word_t mem_wdata;
  soc_pkg::strb_t mem_wstrb;
  soc_pkg::word_t mem_rdata;
  logic           mem_ready;
  logic           msip;
  logic           mtip;

  soc_pkg::word_t ram_model [`NUM_BANKS][`BANK_WORDS];
  soc_pkg::word_t cmp_lo;
  soc_pkg::word_t cmp_hi;
  int             cycle_count;

  soc UUT
  (
    .clock     (clock),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready),
    .msip      (msip),
    .mtip      (mtip)
  );

  bind bus_decoder soc_asserts soc_asserts_comp
  (
    .clock       (clock),
    .rst_n       (rst_n),
    .valid       (valid),
    .addr        (addr),
    .bank_valid  (bank_valid),
    .clint_valid (clint_valid),
    .miss_ready  (miss_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail %s: actual 0x%h expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic soc_pkg::word_t merge_bytes(input soc_pkg::word_t old,
                                                 input soc_pkg::word_t data,
                                                 input soc_pkg::strb_t strb);
    soc_pkg::word_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic is_mapped(input soc_pkg::addr_t a);
    return (a < RAM_BYTES) || (a >= `CLINT_BASE && a < `CLINT_BASE + `CLINT_SIZE);
  endfunction

  // One request, ready expected one edge after valid is sampled.
  task automatic bus_access(input soc_pkg::addr_t addr, input soc_pkg::word_t wdata,
                            input soc_pkg::strb_t wstrb, output soc_pkg::word_t rdata);
    int edges;
    @(negedge clock);
    check_value("mem_ready", mem_ready, 0);  // Previous reply is over.
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    edges     = 0;
    do begin
      @(negedge clock);
      edges++;
    end while (!mem_ready && edges < 4);
    check_value("mem_ready latency", edges, 1);
    rdata     = mem_rdata;
    mem_valid = 1'b0;
    mem_wstrb = '0;
  endtask

  task automatic wait_for_mtip(input logic level);
    int edges;
    edges = 0;
    while (mtip !== level && edges < 4) begin
      @(negedge clock);
      edges++;
    end
    check_value("mtip", mtip, level);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(negedge clock);
      cycle_count++;
      if (UUT.bus_decoder_comp.soc_asserts_comp.fail_count != 0) begin
        stop_with_failure("A bus assertion failed");
      end
      if (cycle_count >= TIMEOUT_CYCLES) begin
        stop_with_failure("Timeout: the tests did not finish within the cycle limit");
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    soc_pkg::addr_t a;
    soc_pkg::word_t wd;
    soc_pkg::word_t rd;
    soc_pkg::word_t prev;
    soc_pkg::strb_t st;
    int unsigned    seed_ret;

    seed_ret  = $urandom(53656);
    rst_n     = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    repeat (3) @(negedge clock);
    rst_n = 1'b1;
    @(negedge clock);  // One edge of mtime against mtimecmp.
    check_value("mem_ready", mem_ready, 0);
    check_value("msip", msip, 0);
    check_value("mtip", mtip, 0);

    for (int i = 0; i < RAM_WORDS; i++) begin  // Known contents first.
      a  = `RAM_BASE + 4 * i;
      wd = (a * 32'h0001_0003) ^ 32'h5A5A_A5A5;
      bus_access(a, wd, 4'hF, rd);
      ram_model[a[11:10]][a[9:2]] = wd;
    end

    for (int i = 0; i < NUM_RAM_OPS; i++) begin
      a  = `RAM_BASE + (($urandom % RAM_BYTES) & ~32'd3);
      wd = $urandom;
      st = ($urandom % 2) ? soc_pkg::strb_t'($urandom_range(1, 15)) : 4'h0;
      bus_access(a, wd, st, rd);
      if (st != 0) begin
        ram_model[a[11:10]][a[9:2]] = merge_bytes(ram_model[a[11:10]][a[9:2]], wd, st);
      end else begin
        check_value("mem_rdata", rd, ram_model[a[11:10]][a[9:2]]);
      end
    end

    for (int i = 0; i < NUM_MISS_OPS; i++) begin
      do begin
        a = $urandom & ~32'd3;
      end while (is_mapped(a));
      bus_access(a, $urandom, soc_pkg::strb_t'($urandom), rd);
      check_value("mem_rdata on miss", rd, 0);
      a = a & (RAM_BYTES - 1);  // Same offset inside the RAM.
      bus_access(a, '0, 4'h0, rd);
      check_value("mem_rdata after miss", rd, ram_model[a[11:10]][a[9:2]]);
    end

    bus_access(`CLINT_BASE + `MSIP_OFS, 32'h1, 4'h1, rd);
    check_value("msip", msip, 1);
    bus_access(`CLINT_BASE + `MSIP_OFS, 32'h0, 4'h0, rd);
    check_value("msip readback", rd, 1);
    bus_access(`CLINT_BASE + `MSIP_OFS, 32'h0, 4'h1, rd);
    check_value("msip", msip, 0);

    cmp_lo = '1;
    cmp_hi = '1;
    for (int i = 0; i < 6; i++) begin
      wd = $urandom;
      st = soc_pkg::strb_t'($urandom_range(1, 15));
      if ($urandom % 2) begin
        bus_access(`CLINT_BASE + `MTIMECMP_HI_OFS, wd, st, rd);
        cmp_hi = merge_bytes(cmp_hi, wd, st);
      end else begin
        bus_access(`CLINT_BASE + `MTIMECMP_LO_OFS, wd, st, rd);
        cmp_lo = merge_bytes(cmp_lo, wd, st);
      end
    end
    bus_access(`CLINT_BASE + `MTIMECMP_LO_OFS, '0, 4'h0, rd);
    check_value("mtimecmp_lo", rd, cmp_lo);
    bus_access(`CLINT_BASE + `MTIMECMP_HI_OFS, '0, 4'h0, rd);
    check_value("mtimecmp_hi", rd, cmp_hi);

    bus_access(`CLINT_BASE + `MTIME_LO_OFS, '0, 4'h0, prev);
    for (int i = 0; i < 4; i++) begin
      bus_access(`CLINT_BASE + `MTIME_LO_OFS, '0, 4'h0, rd);
      if (!(rd > prev)) begin
        stop_with_failure("mtime low did not increase between two reads");
      end
      prev = rd;
    end

    bus_access(`CLINT_BASE + `MTIMECMP_HI_OFS, '0, 4'hF, rd);
    bus_access(`CLINT_BASE + `MTIMECMP_LO_OFS, '0, 4'hF, rd);
    wait_for_mtip(1'b1);
    bus_access(`CLINT_BASE + `MTIMECMP_HI_OFS, 32'h1, 4'hF, rd);  // Far above mtime.
    wait_for_mtip(1'b0);
    bus_access(`CLINT_BASE + `MTIMECMP_HI_OFS, '0, 4'h0, rd);
    check_value("mtimecmp_hi", rd, 1);

    @(negedge clock);
    if (UUT.bus_decoder_comp.soc_asserts_comp.fail_count != 0) begin
      stop_with_failure("A bus assertion failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* soc_asserts.sv */
`default_nettype none

`include "soc_config.svh"

module soc_asserts
(
  input wire                      clock,
  input wire                      rst_n,
  input wire                      valid,
  input wire [31 : 0]             addr,
  input wire [`NUM_BANKS-1 : 0]   bank_valid,
  input wire                      clint_valid,
  input wire                      miss_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31 : 0] RAM_END = `RAM_BASE + `NUM_BANKS * `BANK_WORDS * 4;

  int unsigned fail_count = 0;
  logic        in_ram;
  logic        in_clint;

  // Address map as plain ranges.
  assign in_ram   = (addr >= `RAM_BASE) && (addr < RAM_END);
  assign in_clint = (addr >= `CLINT_BASE) && (addr < `CLINT_BASE + `CLINT_SIZE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake and select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  miss_pulse: assert property (@(posedge clock) disable iff (!rst_n)
    valid && !in_ram && !in_clint && !miss_ready |=> miss_ready ##1 !miss_ready)
  else begin
    fail_count++;
    $error("unmapped request not answered by a single ready pulse");
  end

  one_target: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0({bank_valid, clint_valid}) &&
    (clint_valid == (valid && in_clint)) &&
    (bank_valid == ((valid && in_ram) ? 1 << addr[11 : 10] : 0)))
  else begin
    fail_count++;
    $error("slave valid does not match the address map");
  end

  miss_cause: assert property (@(posedge clock) disable iff (!rst_n)
    miss_ready |-> $past(valid && !in_ram && !in_clint))
  else begin
    fail_count++;
    $error("miss_ready without an unmapped request");
  end

endmodule

`default_nettype wire

/* soc.sv */
`default_nettype none

`include "soc_config.svh"

module soc
(
  input wire                 clock,
  input wire                 rst_n,
  input wire                 mem_valid,
  input wire soc_pkg::addr_t mem_addr,
  input wire soc_pkg::word_t mem_wdata,
  input wire soc_pkg::strb_t mem_wstrb,
  output soc_pkg::word_t     mem_rdata,
  output logic               mem_ready,
  output logic               msip,
  output logic               mtip
);

  mem_bus_if bank_bus [`NUM_BANKS] ();
  mem_bus_if clint_bus ();

  logic miss_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  bus_decoder bus_decoder_comp
  (
    .clock      (clock),
    .rst_n      (rst_n),
    .valid      (mem_valid),
    .addr       (mem_addr),
    .wdata      (mem_wdata),
    .wstrb      (mem_wstrb),
    .bank_bus   (bank_bus),
    .clint_bus  (clint_bus),
    .miss_ready (miss_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slaves
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    ram_bank ram_bank_comp
    (
      .clock (clock),
      .rst_n (rst_n),
      .bus   (bank_bus[i])
    );
  end

  clint clint_comp
  (
    .clock (clock),
    .rst_n (rst_n),
    .bus   (clint_bus),
    .msip  (msip),
    .mtip  (mtip)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reply side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  response_mux response_mux_comp
  (
    .bank_bus   (bank_bus),
    .clint_bus  (clint_bus),
    .miss_ready (miss_ready),
    .rdata      (mem_rdata),
    .ready      (mem_ready)
  );

endmodule

`default_nettype wire

/* response_mux.sv */
`default_nettype none

`include "soc_config.svh"

module response_mux
(
  mem_bus_if.reply       bank_bus [`NUM_BANKS],
  mem_bus_if.reply       clint_bus,
  input wire             miss_ready,
  output soc_pkg::word_t rdata,
  output logic           ready
);

  logic [`NUM_BANKS-1 : 0] bank_ready;
  soc_pkg::word_t          bank_rdata [`NUM_BANKS];

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    assign bank_ready[i] = bank_bus[i].ready;
    assign bank_rdata[i] = bank_bus[i].rdata;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ready = miss_ready | clint_bus.ready | (|bank_ready);

    // At most one slave replies; a miss contributes no data.
    rdata = clint_bus.ready ? clint_bus.rdata : '0;
    for (int i = 0; i < `NUM_BANKS; i++) begin
      if (bank_ready[i]) begin
        rdata = rdata | bank_rdata[i];
      end
    end
  end

endmodule

`default_nettype wire

/* clint.sv */
`default_nettype none

`include "soc_config.svh"

module clint
(
  input wire         clock,
  input wire         rst_n,
  mem_bus_if.respond bus,
  output logic       msip,
  output logic       mtip
);

  soc_pkg::timer_t mtime;
  soc_pkg::timer_t mtimecmp;
  logic            new_req;
  logic            is_write;

  assign new_req  = bus.valid & ~bus.ready;
  assign is_write = |bus.wstrb;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Timer and handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtime     <= '0;
      mtip      <= 1'b0;
      bus.ready <= 1'b0;
    end else begin
      mtime     <= mtime + 1'b1;           // Free running.
      mtip      <= (mtime >= mtimecmp);
      bus.ready <= new_req;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp <= '1;  // Keeps mtip low.
      msip     <= 1'b0;
    end else if (new_req && is_write) begin
      case (bus.addr)
        `MSIP_OFS: begin
          if (bus.wstrb[0]) begin
            msip <= bus.wdata[0];
          end
        end
        `MTIMECMP_LO_OFS: begin
          for (int b = 0; b < 4; b++) begin
            if (bus.wstrb[b]) begin
              mtimecmp[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
        end
        `MTIMECMP_HI_OFS: begin
          for (int b = 0; b < 4; b++) begin
            if (bus.wstrb[b]) begin
              mtimecmp[32+8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
        end
        default: ;  // mtime is read only.
      endcase
    end
  end

  // Read reply, latched on every new request.
  always_ff @(posedge clock) begin
    if (new_req) begin
      case (bus.addr)
        `MSIP_OFS:        bus.rdata <= {31'b0, msip};
        `MTIMECMP_LO_OFS: bus.rdata <= mtimecmp[31 : 0];
        `MTIMECMP_HI_OFS: bus.rdata <= mtimecmp[63 : 32];
        `MTIME_LO_OFS:    bus.rdata <= mtime[31 : 0];
        `MTIME_HI_OFS:    bus.rdata <= mtime[63 : 32];
        default:          bus.rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* ram_bank.sv */
`default_nettype none

`include "soc_config.svh"

module ram_bank
(
  input wire         clock,
  input wire         rst_n,
  mem_bus_if.respond bus
);

  localparam int IDX_BITS = $clog2(`BANK_WORDS);

  soc_pkg::word_t mem [`BANK_WORDS];

  logic [IDX_BITS-1 : 0] word_idx;
  logic                  new_req;
  logic                  is_write;

  assign word_idx = bus.addr[IDX_BITS+1 : 2];  // Bank bits above are ignored.
  assign new_req  = bus.valid & ~bus.ready;
  assign is_write = |bus.wstrb;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (new_req) begin
      if (is_write) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.wstrb[b]) begin
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        bus.rdata <= mem[word_idx];
      end
    end
  end

  // Ready only in the cycle after a new request.
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= new_req;
    end
  end

endmodule

`default_nettype wire

/* bus_decoder.sv */
`default_nettype none

`include "soc_config.svh"

module bus_decoder
(
  input wire                 clock,
  input wire                 rst_n,
  input wire                 valid,
  input wire soc_pkg::addr_t addr,
  input wire soc_pkg::word_t wdata,
  input wire soc_pkg::strb_t wstrb,
  mem_bus_if.request         bank_bus [`NUM_BANKS],
  mem_bus_if.request         clint_bus,
  output logic               miss_ready
);

  localparam soc_pkg::addr_t RAM_SIZE = soc_pkg::addr_t'(`NUM_BANKS * `BANK_WORDS * 4);
  localparam int BANK_LSB = $clog2(`BANK_WORDS) + 2;

  soc_pkg::addr_t          clint_ofs;
  soc_pkg::addr_t          ram_ofs;
  soc_pkg::addr_t          offset;
  soc_pkg::bank_idx_t      bank_sel;
  logic [`NUM_BANKS-1 : 0] bank_valid;
  logic                    clint_valid;
  logic                    miss;

  // Wraps below the base, so one compare covers both bounds.
  assign clint_ofs = addr - `CLINT_BASE;
  assign ram_ofs   = addr - `RAM_BASE;
  assign bank_sel  = soc_pkg::bank_idx_t'(ram_ofs >> BANK_LSB);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Region select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    bank_valid  = '0;
    clint_valid = 1'b0;
    miss        = 1'b0;
    offset      = '0;
    if (clint_ofs < `CLINT_SIZE) begin
      clint_valid = valid;
      offset      = clint_ofs;
    end else if (ram_ofs < RAM_SIZE) begin
      bank_valid[bank_sel] = valid;
      offset               = ram_ofs;  // Bank bits stay in.
    end else begin
      miss = valid;
    end
  end

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    assign bank_bus[i].valid = bank_valid[i];
    assign bank_bus[i].addr  = offset;
    assign bank_bus[i].wdata = wdata;
    assign bank_bus[i].wstrb = wstrb;
  end

  assign clint_bus.valid = clint_valid;
  assign clint_bus.addr  = offset;
  assign clint_bus.wdata = wdata;
  assign clint_bus.wstrb = wstrb;

  // Unmapped reply, one cycle like the slaves.
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      miss_ready <= 1'b0;
    end else begin
      miss_ready <= miss & ~miss_ready;
    end
  end

endmodule

`default_nettype wire

/* mem_bus_if.sv */
`default_nettype none

`include "soc_config.svh"

interface mem_bus_if;

  logic [0  : 0] valid;
  logic [31 : 0] addr;   // Offset from the region base.
  logic [31 : 0] wdata;
  logic [3  : 0] wstrb;  // All zero means read.
  logic [31 : 0] rdata;
  logic [0  : 0] ready;

  modport request
  (
    output valid,
    output addr,
    output wdata,
    output wstrb
  );

  modport respond
  (
    input  valid,
    input  addr,
    input  wdata,
    input  wstrb,
    output rdata,
    output ready
  );

  modport reply
  (
    input rdata,
    input ready
  );

endinterface

`default_nettype wire

/* soc_pkg.sv */
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

  // Byte address on the memory port.
  typedef logic [31 : 0] addr_t;

  typedef logic [31 : 0] word_t;

  // One strobe per byte lane.
  typedef logic [3 : 0] strb_t;

  // Width of mtime and mtimecmp.
  typedef logic [63 : 0] timer_t;

  typedef logic [$clog2(`NUM_BANKS)-1 : 0] bank_idx_t;  // Bank number.

endpackage

`default_nettype wire

/* soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define RAM_BASE        32'h0000_0000
`define NUM_BANKS       4
`define BANK_WORDS      256             // 1 KiB per bank.

`define CLINT_BASE      32'h0200_0000
`define CLINT_SIZE      32'h0001_0000

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MSIP_OFS        32'h0000_0000
`define MTIMECMP_LO_OFS 32'h0000_4000
`define MTIMECMP_HI_OFS 32'h0000_4004
`define MTIME_LO_OFS    32'h0000_BFF8
`define MTIME_HI_OFS    32'h0000_BFFC

`endif
